// File: Makefile
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f filelist.f --top-module tb_keymapper -Mdir $(BUILD) -o tb_keymapper

run: compile
	./$(BUILD)/tb_keymapper | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: filelist.f
+incdir+include
logic/ps2_keymap_pkg.sv
logic/keymap_lookup.sv
logic/prefix_tracker.sv
logic/joystick_emulator.sv
logic/key_output.sv
logic/ps2_amiga_keymapper.sv
sim/tb_keymapper.sv

// File: include/keymap_table.svh
//##########################################################
// case items only, expects a 9-bit {extended, code} selector
// and a keymap_entry_t named table_word in the including block
//##########################################################
`ifndef KEYMAP_TABLE_SVH
`define KEYMAP_TABLE_SVH
9'h001: table_word = 16'h8058;  // F9
9'h003: table_word = 16'h8054;  // F5
9'h004: table_word = 16'h8052;  // F3
9'h005: table_word = 16'h8050;  // F1
9'h006: table_word = 16'h8051;  // F2
9'h007: table_word = 16'h0169;  // F12, opens the OSD
9'h009: table_word = 16'h8059;  // F10
9'h00a: table_word = 16'h8057;  // F8
9'h00b: table_word = 16'h8055;  // F6
9'h00c: table_word = 16'h8053;  // F4
9'h00d: table_word = 16'h8042;  // tab
9'h00e: table_word = 16'h8000;  // backtick
9'h011: table_word = 16'ha064;  // left alt
9'h012: table_word = 16'h8060;  // left shift
9'h014: table_word = 16'hc063;  // ctrl
9'h015: table_word = 16'h8010;  // q
9'h016: table_word = 16'h8001;  // 1
9'h01a: table_word = 16'h8031;  // z
9'h01b: table_word = 16'h8021;  // s
9'h01c: table_word = 16'h8020;  // a
9'h01d: table_word = 16'h8011;  // w
9'h01e: table_word = 16'h8002;  // 2
9'h021: table_word = 16'h8033;  // c
9'h022: table_word = 16'h8032;  // x
9'h023: table_word = 16'h8022;  // d
9'h024: table_word = 16'h8012;  // e
9'h025: table_word = 16'h8004;  // 4
9'h026: table_word = 16'h8003;  // 3
9'h029: table_word = 16'h8040;  // space
9'h02a: table_word = 16'h8034;  // v
9'h02b: table_word = 16'h8023;  // f
9'h02c: table_word = 16'h8014;  // t
9'h02d: table_word = 16'h8013;  // r
9'h02e: table_word = 16'h8005;  // 5
9'h031: table_word = 16'h8036;  // n
9'h032: table_word = 16'h8035;  // b
9'h033: table_word = 16'h8025;  // h
9'h034: table_word = 16'h8024;  // g
9'h035: table_word = 16'h8015;  // y
9'h036: table_word = 16'h8006;  // 6
9'h03a: table_word = 16'h8037;  // m
9'h03b: table_word = 16'h8026;  // j
9'h03c: table_word = 16'h8016;  // u
9'h03d: table_word = 16'h8007;  // 7
9'h03e: table_word = 16'h8008;  // 8
9'h041: table_word = 16'h8038;  // comma
9'h042: table_word = 16'h8027;  // k
9'h043: table_word = 16'h8017;  // i
9'h044: table_word = 16'h8018;  // o
9'h045: table_word = 16'h800a;  // 0
9'h046: table_word = 16'h8009;  // 9
9'h049: table_word = 16'h8039;  // period
9'h04a: table_word = 16'h803a;  // slash
9'h04b: table_word = 16'h8028;  // l
9'h04c: table_word = 16'h8029;  // semicolon
9'h04d: table_word = 16'h8019;  // p
9'h04e: table_word = 16'h800b;  // minus
9'h052: table_word = 16'h802a;  // quote
9'h054: table_word = 16'h801a;  // left bracket
9'h055: table_word = 16'h800c;  // equals
9'h058: table_word = 16'h8862;  // caps lock
9'h059: table_word = 16'h8061;  // right shift
9'h05a: table_word = 16'h8044;  // enter
9'h05b: table_word = 16'h801b;  // right bracket
9'h05d: table_word = 16'h802b;  // iso hash key
9'h061: table_word = 16'h8030;  // iso angle bracket key
9'h066: table_word = 16'h8041;  // backspace
9'h069: table_word = 16'h821d;  // kp 1
9'h06b: table_word = 16'h822d;  // kp 4
9'h06c: table_word = 16'h823d;  // kp 7
9'h070: table_word = 16'h820f;  // kp 0
9'h071: table_word = 16'h823c;  // kp point
9'h072: table_word = 16'h821e;  // kp 2
9'h073: table_word = 16'h822e;  // kp 5
9'h074: table_word = 16'h822f;  // kp 6
9'h075: table_word = 16'h823e;  // kp 8
9'h076: table_word = 16'h8045;  // escape
9'h077: table_word = 16'h0400;  // num lock, never sent to the Amiga
9'h079: table_word = 16'h825e;  // kp plus
9'h07a: table_word = 16'h821f;  // kp 3
9'h07b: table_word = 16'h824a;  // kp minus
9'h07c: table_word = 16'h825d;  // kp star
9'h07d: table_word = 16'h823f;  // kp 9
9'h07e: table_word = 16'h0169;  // scroll lock, same as F12
9'h083: table_word = 16'h8056;  // F7
9'h0e0: table_word = 16'h0081;  // E0 prefix
9'h0f0: table_word = 16'h0082;  // F0 release prefix
9'h0fa: table_word = 16'h0084;  // FA keyboard ack
9'h111: table_word = 16'h9065;  // right alt
9'h11f: table_word = 16'h8066;  // left gui as left Amiga
9'h127: table_word = 16'h8067;  // right gui as right Amiga
9'h12f: table_word = 16'h8067;  // apps key, also right Amiga
9'h14a: table_word = 16'h825c;  // kp slash
9'h15a: table_word = 16'h8243;  // kp enter
9'h169: table_word = 16'h016b;  // end
9'h16b: table_word = 16'h804f;  // cursor left
9'h16c: table_word = 16'h016a;  // home
9'h170: table_word = 16'h805f;  // insert as help
9'h171: table_word = 16'h8046;  // delete
9'h172: table_word = 16'h804d;  // cursor down
9'h174: table_word = 16'h804e;  // cursor right
9'h175: table_word = 16'h804c;  // cursor up
9'h17a: table_word = 16'h016d;  // page down
9'h17c: table_word = 16'h016e;  // print screen
9'h17d: table_word = 16'h016c;  // page up
9'h17e: table_word = 16'h016f;  // ctrl break
9'h1e0: table_word = 16'h0081;  // E0 seen again while extended
9'h1f0: table_word = 16'h0082;  // E0 F0 release
9'h1fa: table_word = 16'h0084;  // ack while extended
default: table_word = '0;       // unmapped codes still clear the prefix state
`endif

// File: logic/joystick_emulator.sv
//##########################################################
// num-lock mode turns the cursor keys, ctrl and left alt into
// a joystick, all lines high while num-lock is off
//##########################################################
`timescale 1ns/1ps

module joystick_emulator (
  input  logic                               clk,
  input  logic                               reset,
  input  ps2_keymap_pkg::keymap_entry_t      entry,
  input  logic                               entry_strobe,
  input  logic                               upstroke,
  output logic                               numlock,
  output logic [ps2_keymap_pkg::JOY_W-1:0]   joy_n
);

  logic key_event;  // strobed Amiga key entry

  assign key_event = entry_strobe && entry.key.valid_key;

  // toggles on the make code only
  always_ff @(posedge clk) begin
    if (reset) begin
      numlock <= 1'b0;
    end else if (entry_strobe && entry.key.numlock_key && !upstroke) begin
      numlock <= !numlock;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || !numlock) begin
      joy_n <= '1;
    end else if (key_event) begin
      // a press releases the opposite direction
      case (entry.key.code)
        ps2_keymap_pkg::JOY_KEY_UP: begin
          joy_n[ps2_keymap_pkg::JOY_UP] <= upstroke;
          if (!upstroke) begin
            joy_n[ps2_keymap_pkg::JOY_DOWN] <= 1'b1;
          end
        end
        ps2_keymap_pkg::JOY_KEY_DOWN: begin
          joy_n[ps2_keymap_pkg::JOY_DOWN] <= upstroke;
          if (!upstroke) begin
            joy_n[ps2_keymap_pkg::JOY_UP] <= 1'b1;
          end
        end
        ps2_keymap_pkg::JOY_KEY_LEFT: begin
          joy_n[ps2_keymap_pkg::JOY_LEFT] <= upstroke;
          if (!upstroke) begin
            joy_n[ps2_keymap_pkg::JOY_RIGHT] <= 1'b1;
          end
        end
        ps2_keymap_pkg::JOY_KEY_RIGHT: begin
          joy_n[ps2_keymap_pkg::JOY_RIGHT] <= upstroke;
          if (!upstroke) begin
            joy_n[ps2_keymap_pkg::JOY_LEFT] <= 1'b1;
          end
        end
        default: begin
        end
      endcase
      if (entry.key.ctrl) begin
        joy_n[ps2_keymap_pkg::JOY_FIRE] <= upstroke;   // low while held
      end
      if (entry.key.left_alt) begin
        joy_n[ps2_keymap_pkg::JOY_FIRE2] <= upstroke;
      end
    end
  end

  a_no_up_and_down: assert property (
    @(posedge clk) disable iff (reset)
      joy_n[ps2_keymap_pkg::JOY_UP] || joy_n[ps2_keymap_pkg::JOY_DOWN]
  );

endmodule

// File: logic/key_output.sv
//##########################################################
// key outputs are combinational from the held entry
// OSD byte and strobe lag one cycle behind entry_strobe
//##########################################################
`timescale 1ns/1ps

module key_output (
  input  logic                                    clk,
  input  logic                                    reset,
  input  ps2_keymap_pkg::keymap_entry_t           entry,
  input  logic                                    entry_strobe,
  input  logic                                    upstroke,
  input  logic                                    numlock,
  output logic                                    valid,
  output logic [ps2_keymap_pkg::AMIGA_CODE_W:0]   akey,
  output logic                                    ctrl,
  output logic                                    left_alt,
  output logic                                    right_alt,
  output logic                                    caps,
  output logic [ps2_keymap_pkg::AMIGA_CODE_W:0]   osd_ctrl,
  output logic                                    osd_strobe
);

  logic dir_key;     // cursor key, taken over by the joystick
  logic joy_owned;   // key reserved for the joystick in num-lock mode
  logic osd_event;

  assign dir_key = (entry.key.code == ps2_keymap_pkg::JOY_KEY_UP)   ||
                   (entry.key.code == ps2_keymap_pkg::JOY_KEY_DOWN) ||
                   (entry.key.code == ps2_keymap_pkg::JOY_KEY_LEFT) ||
                   (entry.key.code == ps2_keymap_pkg::JOY_KEY_RIGHT);

  assign joy_owned = numlock &&
                     (entry.key.keypad || dir_key || entry.key.ctrl || entry.key.left_alt);

  assign valid = entry_strobe && entry.key.valid_key && !joy_owned;
  assign akey  = {upstroke, entry.key.code};  // msb set on key release

  // fire buttons are ctrl and left alt, hide them from the Amiga
  assign ctrl      = entry.key.ctrl && !numlock;
  assign left_alt  = entry.key.left_alt && !numlock;
  assign right_alt = entry.key.right_alt;
  assign caps      = entry.key.caps;

  // the OSD sees every Amiga key plus its own extra keys
  assign osd_event = entry_strobe && (entry.key.osd_key || entry.key.valid_key);

  always_ff @(posedge clk) begin
    if (reset) begin
      osd_ctrl   <= '0;
      osd_strobe <= 1'b0;
    end else begin
      osd_strobe <= osd_event;
      if (osd_event) begin
        osd_ctrl <= {upstroke, entry.key.code};
      end
    end
  end

  // no table word has both the key and prefix bits, so prefixes never reach the Amiga
  a_valid_is_key: assert property (
    @(posedge clk) disable iff (reset) valid |-> !entry.key.prefix
  );

endmodule

// File: logic/keymap_lookup.sv
//##########################################################
// enable must not be high on two cycles in a row
//##########################################################
`timescale 1ns/1ps

module keymap_lookup (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      enable,
  input  logic [ps2_keymap_pkg::PS2_CODE_W-1:0]     ps2_code,
  input  logic                                      extended,
  output ps2_keymap_pkg::keymap_entry_t             entry,
  output logic                                      entry_strobe
);

  logic [ps2_keymap_pkg::PS2_CODE_W:0] addr;  // {extended, scan code}
  ps2_keymap_pkg::keymap_entry_t        table_word;

  assign addr = {extended, ps2_code};

  // table ROM, maps onto a block RAM once registered below
  always_comb begin
    case (addr)
      `include "keymap_table.svh"
    endcase
  end

  // entry holds until the next scan code arrives
  always_ff @(posedge clk) begin
    if (reset) begin
      entry <= '0;
    end else if (enable) begin
      entry <= table_word;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      entry_strobe <= 1'b0;
    end else begin
      entry_strobe <= enable;  // marks the cycle the new entry is visible
    end
  end

  // prefix state needs one idle cycle to feed back into addr
  a_enable_spacing: assert property (
    @(posedge clk) disable iff (reset) enable |=> !enable
  );

endmodule

// File: logic/prefix_tracker.sv
//##########################################################
// tracks E0 and F0 prefixes, FA acks pass without effect
//##########################################################
`timescale 1ns/1ps

module prefix_tracker (
  input  logic                          clk,
  input  logic                          reset,
  input  ps2_keymap_pkg::keymap_entry_t entry,
  input  logic                          entry_strobe,
  output logic                          extended,
  output logic                          upstroke
);

  logic prefix_hit;  // strobed entry is a prefix word
  logic is_ack;

  assign prefix_hit = entry_strobe && entry.pfx.prefix;
  assign is_ack     = entry.pfx.prefix && entry.pfx.ack;

  // the key code after the prefixes consumes the state
  always_ff @(posedge clk) begin
    if (reset) begin
      extended <= 1'b0;
      upstroke <= 1'b0;
    end else if (prefix_hit && entry.pfx.extended) begin
      extended <= 1'b1;
    end else if (prefix_hit && entry.pfx.release_code) begin
      upstroke <= 1'b1;
    end else if (entry_strobe && !is_ack) begin
      extended <= 1'b0;
      upstroke <= 1'b0;
    end
  end

  // E0 and F0 arrive as separate codes, no prefix word carries both bits
  a_single_prefix: assert property (
    @(posedge clk) disable iff (reset)
      prefix_hit |-> !(entry.pfx.extended && entry.pfx.release_code)
  );

endmodule

// File: logic/ps2_amiga_keymapper.sv
//##########################################################
// one scan code per enable strobe, at most every other cycle
// no back-pressure, outputs are never stalled
//##########################################################
`timescale 1ns/1ps

module ps2_amiga_keymapper (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    enable,
  input  logic [ps2_keymap_pkg::PS2_CODE_W-1:0]   ps2_code,
  output logic                                    valid,
  output logic [ps2_keymap_pkg::AMIGA_CODE_W:0]   akey,
  output logic                                    ctrl,
  output logic                                    left_alt,
  output logic                                    right_alt,
  output logic                                    caps,
  output logic                                    numlock,
  output logic [ps2_keymap_pkg::AMIGA_CODE_W:0]   osd_ctrl,
  output logic                                    osd_strobe,
  output logic [ps2_keymap_pkg::JOY_W-1:0]        joy_n
);

  ps2_keymap_pkg::keymap_entry_t entry;
  logic                          entry_strobe;
  logic                          extended;   // fed back into the lookup address
  logic                          upstroke;

  keymap_lookup i_lookup (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable),
    .ps2_code     (ps2_code),
    .extended     (extended),
    .entry        (entry),
    .entry_strobe (entry_strobe)
  );

  prefix_tracker i_prefix (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .entry_strobe (entry_strobe),
    .extended     (extended),
    .upstroke     (upstroke)
  );

  joystick_emulator i_joystick (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .entry_strobe (entry_strobe),
    .upstroke     (upstroke),
    .numlock      (numlock),
    .joy_n        (joy_n)
  );

  key_output i_output (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .entry_strobe (entry_strobe),
    .upstroke     (upstroke),
    .numlock      (numlock),
    .valid        (valid),
    .akey         (akey),
    .ctrl         (ctrl),
    .left_alt     (left_alt),
    .right_alt    (right_alt),
    .caps         (caps),
    .osd_ctrl     (osd_ctrl),
    .osd_strobe   (osd_strobe)
  );

endmodule

// File: logic/ps2_keymap_pkg.sv
//##########################################################
// keymap table word layout and key constants, Set 2 scan codes only
// one 16-bit word is read as a key entry or as a prefix entry
//##########################################################
package ps2_keymap_pkg;

  localparam int PS2_CODE_W   = 8;  // raw scan code from the PS/2 receiver
  localparam int AMIGA_CODE_W = 7;  // Amiga raw key code without up/down bit
  localparam int JOY_W        = 6;  // emulated joystick lines

  // Amiga cursor key codes, reused as joystick directions
  localparam logic [AMIGA_CODE_W-1:0] JOY_KEY_UP    = 7'h4C;
  localparam logic [AMIGA_CODE_W-1:0] JOY_KEY_DOWN  = 7'h4D;
  localparam logic [AMIGA_CODE_W-1:0] JOY_KEY_LEFT  = 7'h4F;
  localparam logic [AMIGA_CODE_W-1:0] JOY_KEY_RIGHT = 7'h4E;

  // bit positions in joy_n, all active low
  localparam int JOY_RIGHT = 0;
  localparam int JOY_LEFT  = 1;
  localparam int JOY_DOWN  = 2;
  localparam int JOY_UP    = 3;
  localparam int JOY_FIRE  = 4;
  localparam int JOY_FIRE2 = 5;

  // entry for a real key, prefix bit clear
  typedef struct packed {
    logic                    valid_key;    // key exists on the Amiga side
    logic                    ctrl;
    logic                    left_alt;
    logic                    right_alt;
    logic                    caps;
    logic                    numlock_key;
    logic                    keypad;       // masked while num-lock is on
    logic                    osd_key;      // extra key only seen by the OSD
    logic                    prefix;
    logic [AMIGA_CODE_W-1:0] code;
  } key_fields_t;

  // entry for E0, F0 and FA, prefix bit set
  typedef struct packed {
    logic [7:0] unused_hi;
    logic       prefix;
    logic [3:0] unused_lo;
    logic       ack;
    logic       release_code;
    logic       extended;
  } prefix_fields_t;

  // the prefix bit sits at bit 7 in both views
  typedef union packed {
    key_fields_t    key;
    prefix_fields_t pfx;
  } keymap_entry_t;

endpackage

// File: sim/tb_keymapper.sv
//############################################################
// directed tests, each scan code is followed by two idle cycles
// valid and OSD pulses are captured on the falling clock edge
//############################################################
`timescale 1ns/1ps

module tb_keymapper;

  localparam int CLK_PERIOD  = 8;
  localparam int WAIT_LIMIT  = 20;      // cycles allowed for any single wait
  localparam int WATCHDOG_NS = 100000;

  // joy_n lines, a set bit here means the line is expected low
  localparam logic [5:0] UP_MASK    = 6'(1 << ps2_keymap_pkg::JOY_UP);
  localparam logic [5:0] DOWN_MASK  = 6'(1 << ps2_keymap_pkg::JOY_DOWN);
  localparam logic [5:0] FIRE_MASK  = 6'(1 << ps2_keymap_pkg::JOY_FIRE);
  localparam logic [5:0] FIRE2_MASK = 6'(1 << ps2_keymap_pkg::JOY_FIRE2);

  logic       clk;
  logic       reset;
  logic       enable;
  logic [7:0] ps2_code;
  logic       valid;
  logic [7:0] akey;
  logic       ctrl;
  logic       left_alt;
  logic       right_alt;
  logic       caps;
  logic       numlock;
  logic [7:0] osd_ctrl;
  logic       osd_strobe;
  logic [5:0] joy_n;

  int         errors;
  int         checks;
  int         tests;
  int         valid_count;   // written by the monitor only
  int         osd_count;
  int         valid_base;    // counts at the start of the last send
  int         osd_base;
  logic [7:0] seen_akey;
  logic       seen_ctrl;
  logic       seen_left_alt;
  logic       seen_right_alt;
  logic       seen_caps;
  logic [7:0] seen_osd;

  ps2_amiga_keymapper i_dut (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .ps2_code   (ps2_code),
    .valid      (valid),
    .akey       (akey),
    .ctrl       (ctrl),
    .left_alt   (left_alt),
    .right_alt  (right_alt),
    .caps       (caps),
    .numlock    (numlock),
    .osd_ctrl   (osd_ctrl),
    .osd_strobe (osd_strobe),
    .joy_n      (joy_n)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // capture pulses away from the rising edge
  always @(negedge clk) begin
    if (valid === 1'b1) begin
      valid_count    = valid_count + 1;
      seen_akey      = akey;
      seen_ctrl      = ctrl;
      seen_left_alt  = left_alt;
      seen_right_alt = right_alt;
      seen_caps      = caps;
    end
    if (osd_strobe === 1'b1) begin
      osd_count = osd_count + 1;
      seen_osd  = osd_ctrl;
    end
  end

  task automatic check_value(input string name, input logic [7:0] got,
                             input logic [7:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_value(name, {7'b0, got}, {7'b0, exp});
  endtask

  task automatic check_joy(input logic [5:0] exp);
    check_value("joy_n", {2'b00, joy_n}, {2'b00, exp});
  endtask

  function automatic int event_count(input bit osd);
    event_count = osd ? (osd_count - osd_base) : (valid_count - valid_base);
  endfunction

  // one enable cycle, then two idle cycles, ends on a falling edge
  task automatic send_code(input logic [7:0] code);
    @(posedge clk);
    valid_base = valid_count;
    osd_base   = osd_count;
    enable   <= 1'b1;
    ps2_code <= code;
    @(posedge clk);
    enable <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic wait_for_event(input bit osd, input string what);
    int cycles;
    bit seen;
    cycles = 0;
    while (event_count(osd) == 0 && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    seen = (event_count(osd) != 0);
    if (cycles != 0) begin
      @(negedge clk);
    end
    checks++;
    assert (seen) else begin
      $display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
      errors++;
    end
  endtask

  task automatic expect_key(input logic [7:0] exp_akey);
    wait_for_event(1'b0, "valid pulse");
    check_value("valid pulses", 8'(event_count(1'b0)), 8'h01);
    check_value("akey", seen_akey, exp_akey);
  endtask

  task automatic expect_no_key();
    check_value("valid pulses", 8'(event_count(1'b0)), 8'h00);
  endtask

  task automatic expect_osd(input logic [7:0] exp_osd);
    wait_for_event(1'b1, "OSD strobe");
    check_value("osd_strobe pulses", 8'(event_count(1'b1)), 8'h01);
    check_value("osd_ctrl", seen_osd, exp_osd);
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests++;
    $display("test %s: %0d errors", name, errors - start_errors);
  endtask

  task automatic test_reset();
    int start;
    start = errors;
    check_bit("valid", valid, 1'b0);
    check_bit("osd_strobe", osd_strobe, 1'b0);
    check_bit("numlock", numlock, 1'b0);
    check_value("osd_ctrl", osd_ctrl, 8'h00);
    check_joy(6'h3f);
    check_bit("ctrl", ctrl, 1'b0);
    check_bit("caps", caps, 1'b0);
    report_test("reset", start);
  endtask

  task automatic test_make_break();
    int start;
    start = errors;
    send_code(8'h1c);
    expect_key(8'h20);            // a key make
    send_code(8'hf0);
    expect_no_key();
    send_code(8'h1c);
    expect_key(8'ha0);
    send_code(8'hf0);
    send_code(8'hfa);             // ack between prefix and key
    expect_no_key();
    send_code(8'h1c);
    expect_key(8'ha0);
    report_test("make_break", start);
  endtask

  task automatic test_extended_modifiers();
    int start;
    start = errors;
    send_code(8'he0);
    expect_no_key();
    send_code(8'h75);
    expect_key(8'h4c);            // cursor up
    send_code(8'he0);
    send_code(8'hf0);
    send_code(8'h75);
    expect_key(8'hcc);
    send_code(8'h14);
    expect_key(8'h63);
    check_bit("ctrl", seen_ctrl, 1'b1);
    send_code(8'hf0);
    send_code(8'h14);
    expect_key(8'he3);
    send_code(8'h11);
    expect_key(8'h64);
    check_bit("left_alt", seen_left_alt, 1'b1);
    send_code(8'h58);
    expect_key(8'h62);
    check_bit("caps", seen_caps, 1'b1);
    send_code(8'he0);
    send_code(8'h11);
    expect_key(8'h65);
    check_bit("right_alt", seen_right_alt, 1'b1);
    report_test("extended_modifiers", start);
  endtask

  task automatic test_osd();
    int start;
    start = errors;
    send_code(8'h07);             // F12, OSD only
    expect_osd(8'h69);
    expect_no_key();
    send_code(8'hf0);
    send_code(8'h07);
    expect_osd(8'he9);
    send_code(8'h1c);
    expect_key(8'h20);
    expect_osd(8'h20);
    report_test("osd", start);
  endtask

  task automatic test_numlock_joystick();
    int start;
    start = errors;
    send_code(8'h77);
    expect_no_key();
    check_bit("numlock", numlock, 1'b1);
    send_code(8'hf0);
    send_code(8'h77);             // release must not toggle
    check_bit("numlock", numlock, 1'b1);
    check_joy(6'h3f);
    send_code(8'he0);
    send_code(8'h75);
    expect_no_key();
    check_joy(~UP_MASK);
    send_code(8'he0);
    send_code(8'h72);
    expect_no_key();
    check_joy(~DOWN_MASK);        // down press releases up
    send_code(8'h14);
    expect_no_key();
    check_bit("ctrl", ctrl, 1'b0);
    check_joy(~(DOWN_MASK | FIRE_MASK));
    send_code(8'h6b);             // keypad 4
    expect_no_key();
    send_code(8'h11);
    expect_no_key();
    check_joy(~(DOWN_MASK | FIRE_MASK | FIRE2_MASK));
    send_code(8'hf0);
    send_code(8'h11);
    check_joy(~(DOWN_MASK | FIRE_MASK));
    send_code(8'hf0);
    send_code(8'h14);
    check_joy(~DOWN_MASK);
    send_code(8'he0);
    send_code(8'hf0);
    send_code(8'h72);
    expect_no_key();
    check_joy(6'h3f);
    send_code(8'he0);
    send_code(8'h75);
    check_joy(~UP_MASK);
    send_code(8'h77);             // leaving num-lock releases every line
    check_bit("numlock", numlock, 1'b0);
    check_joy(6'h3f);
    send_code(8'he0);
    send_code(8'hf0);
    send_code(8'h75);
    expect_key(8'hcc);
    report_test("numlock_joystick", start);
  endtask

  initial begin
    errors      = 0;
    checks      = 0;
    tests       = 0;
    valid_count = 0;
    osd_count   = 0;
    valid_base  = 0;
    osd_base    = 0;
    reset       = 1'b1;
    enable      = 1'b0;
    ps2_code    = 8'h00;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    test_reset();
    test_make_break();
    test_extended_modifiers();
    test_osd();
    test_numlock_joystick();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule
